//--- fas.f
+incdir+hw
hw/fas_stream_pkg.sv
hw/fas_coef_pkg.sv
hw/fft_butterfly.sv
hw/fir_filter.sv
hw/frame_buffer.sv
hw/fft16_pipe.sv
hw/fas_top.sv
tb/fas_ref_pkg.sv
tb/tb_clock.sv
tb/fas_tb.sv

//--- hw/fas_coef_pkg.sv
`include "fas_params.svh"

package fas_coef_pkg;

  //////////////////////////////////////////////////////////////////////
  // fir coefficients
  //////////////////////////////////////////////////////////////////////
  typedef logic signed [`FAS_COEF_W-1:0] coef_t;

  // symmetric low-pass, q16, c[k] multiplies sample[n-k]
  localparam coef_t fir_coef [`FAS_TAPS] = '{
    20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B,  // outer taps, tiny
    20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,
    20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74,  // negative side lobe
    20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,  // main lobe rising
    20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A,  // mirror of 12..15
    20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E
  };

  //////////////////////////////////////////////////////////////////////
  // twiddles W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
  //////////////////////////////////////////////////////////////////////
  typedef logic signed [`FAS_TW_W-1:0] twiddle_t;

  // real part, q16
  localparam twiddle_t tw_re [`FAS_FFT_N/2] = '{
    18'sd65536,   // 1.0
    18'sd60547,
    18'sd46340,   // 1/sqrt(2)
    18'sd25079,
    18'sd0,
    -18'sd25079,
    -18'sd46340,
    -18'sd60547
  };

  // imaginary part, already negated
  localparam twiddle_t tw_im [`FAS_FFT_N/2] = '{
    18'sd0,
    -18'sd25079,
    -18'sd46340,
    -18'sd60547,
    -18'sd65536,  // k=4 is -j
    -18'sd60547,
    -18'sd46340,
    -18'sd25079
  };

endpackage

//--- hw/fas_params.svh
`ifndef FAS_PARAMS_SVH
`define FAS_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////
`define FAS_SAMPLE_W 16   // input and filtered sample width
`define FAS_COEF_W   20   // fir coefficient width
`define FAS_TW_W     18   // twiddle width, holds +/-1.0 in q16
`define FAS_ACC_W    24   // fft internal word per real/imag part

// fixed point
`define FAS_FRAC     16   // fraction bits of coefs and twiddles

// structure
`define FAS_TAPS     32   // fir length
`define FAS_FFT_N    16   // samples per frame = fft points

`endif

//--- hw/fas_stream_pkg.sv
`include "fas_params.svh"

package fas_stream_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample stream
  //////////////////////////////////////////////////////////////////////
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    logic    valid;  // qualifies data for one cycle
    sample_t data;
  } sample_s;

  // complex word inside the fft stages
  typedef struct packed {
    logic signed [`FAS_ACC_W-1:0] re;
    logic signed [`FAS_ACC_W-1:0] im;
  } cplx_t;

  //////////////////////////////////////////////////////////////////////
  // frame and spectrum
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                          valid;  // one cycle per full frame
    sample_t [`FAS_FFT_N-1:0]      x;      // x[0] is the oldest sample
  } frame_s;

  typedef struct packed {
    sample_t re;
    sample_t im;
  } bin_t;

  typedef struct packed {
    logic                     valid;
    bin_t [`FAS_FFT_N-1:0]    bin;  // natural order, bin[0] is dc
  } spectrum_s;

endpackage

//--- hw/fas_top.sv
`include "fas_params.svh"

module fas_top (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        data_valid,
  input  fas_stream_pkg::sample_t                     data,
  output logic                                        fir_valid,
  output fas_stream_pkg::sample_t                     fir_d,
  output logic                                        fft_valid,
  output fas_stream_pkg::bin_t [`FAS_FFT_N-1:0]       fft_bins
);
  import fas_stream_pkg::*;

  sample_s   in_s;    // raw input stream
  sample_s   fir_s;   // filtered stream
  frame_s    frm;     // 16 sample frames
  spectrum_s spec;    // fft result

  assign in_s = '{valid: data_valid, data: data};

  fir_filter u_fir (.clk(clk), .rst(rst), .in_s(in_s), .out_s(fir_s));

  frame_buffer u_frm (.clk(clk), .rst(rst), .in_s(fir_s), .frame(frm));

  fft16_pipe u_fft (.clk(clk), .rst(rst), .frame(frm), .spectrum(spec));

  // unpack to the outside
  assign fir_valid = fir_s.valid;
  assign fir_d     = fir_s.data;
  assign fft_valid = spec.valid;
  assign fft_bins  = spec.bin;

endmodule

//--- hw/fft16_pipe.sv
`include "fas_params.svh"

module fft16_pipe (
  input  logic                      clk,
  input  logic                      rst,
  input  fas_stream_pkg::frame_s    frame,
  output fas_stream_pkg::spectrum_s spectrum
);
  import fas_stream_pkg::*;

  localparam int N      = `FAS_FFT_N;
  localparam int STAGES = $clog2(`FAS_FFT_N);
  localparam int SW     = `FAS_SAMPLE_W;
  localparam int AW     = `FAS_ACC_W;

  // reverse the low STAGES bits of an index
  function automatic int bit_rev(input int v);
    int r;
    r = 0;
    for (int b = 0; b < STAGES; b++) begin
      r = (r << 1) | ((v >> b) & 1);
    end
    return r;
  endfunction

  cplx_t      x_in   [N];           // widened frame
  cplx_t      bf_in  [STAGES][N];   // stage inputs
  cplx_t      bf_out [STAGES][N];   // butterfly results, unregistered
  cplx_t      st_q   [STAGES][N];   // stage registers
  logic [STAGES-1:0] vld_q;         // valid travels with its frame

  //////////////////////////////////////////////////////////////////////
  // input widening, real samples only
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < N; i++) begin
      x_in[i].re = {{(AW-SW){frame.x[i][SW-1]}}, frame.x[i]};  // sign extend
      x_in[i].im = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // butterfly network, DIF
  //////////////////////////////////////////////////////////////////////
  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    localparam int H = N >> (s + 1);  // pair distance 8, 4, 2, 1

    if (s == 0) begin : g_src
      assign bf_in[s] = x_in;
    end else begin : g_src
      assign bf_in[s] = st_q[s-1];
    end

    for (genvar j = 0; j < N/2; j++) begin : g_bf
      localparam int         TOP = (j / H) * 2 * H + (j % H);  // upper leg position
      localparam logic [2:0] TW  = 3'((j % H) << s);           // position in group * 2^s

      fft_butterfly u_bf (
        .a      (bf_in[s][TOP]),
        .b      (bf_in[s][TOP+H]),
        .tw_sel (TW),
        .sum    (bf_out[s][TOP]),
        .diff   (bf_out[s][TOP+H])
      );
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pipeline registers, one per stage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int s = 0; s < STAGES; s++) begin
      for (int i = 0; i < N; i++) begin
        st_q[s][i] <= bf_out[s][i];  // free running, valid marks the frame
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) vld_q <= '0;
    else     vld_q <= {vld_q[STAGES-2:0], frame.valid};
  end

  // stage 4 holds bins in bit-reversed order
  always_comb begin
    spectrum.valid = vld_q[STAGES-1];
    for (int k = 0; k < N; k++) begin
      spectrum.bin[k].re = st_q[STAGES-1][bit_rev(k)].re[SW-1:0];  // low bits, no saturation
      spectrum.bin[k].im = st_q[STAGES-1][bit_rev(k)].im[SW-1:0];
    end
  end

endmodule

//--- hw/fft_butterfly.sv
`include "fas_params.svh"

module fft_butterfly (
  input  fas_stream_pkg::cplx_t a,
  input  fas_stream_pkg::cplx_t b,
  input  logic [2:0]            tw_sel,
  output fas_stream_pkg::cplx_t sum,
  output fas_stream_pkg::cplx_t diff
);
  import fas_stream_pkg::*;
  import fas_coef_pkg::*;

  localparam int W  = `FAS_ACC_W;
  localparam int PW = `FAS_ACC_W + `FAS_TW_W + 1;  // product plus one add

  logic signed [W-1:0]  d_re, d_im;     // a - b, wraps at W bits
  twiddle_t             w_re, w_im;
  logic signed [PW-1:0] p_re, p_im;     // complex product, q16

  assign w_re = tw_re[tw_sel];
  assign w_im = tw_im[tw_sel];

  // upper leg
  assign sum.re = a.re + b.re;
  assign sum.im = a.im + b.im;

  //////////////////////////////////////////////////////////////////////
  // lower leg
  //////////////////////////////////////////////////////////////////////
  assign d_re = a.re - b.re;
  assign d_im = a.im - b.im;

  assign p_re = d_re * w_re - d_im * w_im;
  assign p_im = d_re * w_im + d_im * w_re;

  // >>> 16 then keep W bits
  assign diff.re = p_re[`FAS_FRAC +: W];
  assign diff.im = p_im[`FAS_FRAC +: W];

endmodule

//--- hw/fir_filter.sv
`include "fas_params.svh"

module fir_filter (
  input  logic                    clk,
  input  logic                    rst,
  input  fas_stream_pkg::sample_s in_s,
  output fas_stream_pkg::sample_s out_s
);
  import fas_stream_pkg::*;
  import fas_coef_pkg::*;

  localparam int TAPS  = `FAS_TAPS;
  localparam int ACC_W = `FAS_SAMPLE_W + `FAS_COEF_W + $clog2(`FAS_TAPS);  // no overflow

  //////////////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////////////
  sample_t                   dly [TAPS-1];   // dly[0] = previous sample
  logic [$clog2(TAPS):0]     run_cnt;        // consecutive accepted samples, sat at TAPS
  logic                      vld_q;
  sample_t                   dat_q;

  logic signed [ACC_W-1:0]   acc;            // full precision mac
  logic signed [ACC_W-1:0]   shifted;        // q16 removed, rounded toward zero

  //////////////////////////////////////////////////////////////////////
  // multiply-accumulate over the new sample plus 31 stored ones
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    acc = in_s.data * fir_coef[0];  // tap 0 is the sample arriving now
    for (int k = 1; k < TAPS; k++) begin
      acc = acc + dly[k-1] * fir_coef[k];
    end
  end

  // arithmetic shift, bump negatives by one
  assign shifted = (acc >>> `FAS_FRAC) + {{(ACC_W-1){1'b0}}, acc[ACC_W-1]};

  // delay line shifts only on accepted samples, a gap leaves it intact
  always_ff @(posedge clk) begin
    if (in_s.valid) begin
      dly[0] <= in_s.data;
      for (int k = 1; k < TAPS-1; k++) begin
        dly[k] <= dly[k-1];
      end
      dat_q <= shifted[`FAS_SAMPLE_W-1:0];  // keep low bits only
    end
  end

  // run counter and output valid
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_cnt <= '0;
      vld_q   <= 1'b0;
    end else if (in_s.valid) begin
      if (run_cnt < TAPS) run_cnt <= run_cnt + 1'b1;  // saturate
      vld_q <= (run_cnt >= TAPS-1);                   // this sample completes the window
    end else begin
      run_cnt <= '0;  // gap restarts the fill
      vld_q   <= 1'b0;
    end
  end

  assign out_s = '{valid: vld_q, data: dat_q};

endmodule

//--- hw/frame_buffer.sv
`include "fas_params.svh"

module frame_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  fas_stream_pkg::sample_s in_s,
  output fas_stream_pkg::frame_s  frame
);
  import fas_stream_pkg::*;

  sample_t [`FAS_FFT_N-1:0]      slots;     // one frame worth of samples
  logic [$clog2(`FAS_FFT_N)-1:0] idx;       // next slot to write
  logic                          full_q;    // one cycle pulse

  //////////////////////////////////////////////////////////////////////
  // slot storage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (in_s.valid) slots[idx] <= in_s.data;
  end

  // fill index, wraps at the end of each frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      idx    <= '0;
      full_q <= 1'b0;
    end else if (in_s.valid) begin
      idx    <= idx + 1'b1;
      full_q <= &idx;      // last slot written now
    end else begin
      idx    <= '0;        // drop the partial frame
      full_q <= 1'b0;
    end
  end

  // slots are stable for the pulse cycle, slot 15 lands on the same edge
  assign frame = '{valid: full_q, x: slots};

endmodule

//--- run.sh
#!/bin/sh
# build the fas testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module fas_tb -f fas.f -o fas_sim \
  && ./obj_dir/fas_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

//--- tb/fas_ref_pkg.sv
`include "fas_params.svh"

package fas_ref_pkg;
  import fas_stream_pkg::*;
  import fas_coef_pkg::*;

  typedef bin_t [`FAS_FFT_N-1:0] bins_t;  // same layout as fft_bins

  //////////////////////////////////////////////////////////////////////
  // small helpers
  //////////////////////////////////////////////////////////////////////
  // keep the low w bits as two's complement
  function automatic longint wrap(input longint v, input int w);
    longint m;
    m = longint'(1) << w;
    v = v & (m - 1);
    if (v >= (m >>> 1)) v = v - m;
    return v;
  endfunction

  function automatic int reverse_bits(input int v, input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) r = (r << 1) | ((v >> i) & 1);
    return r;
  endfunction

  // galois lfsr x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // filter model, h[k] is sample[n-k]
  //////////////////////////////////////////////////////////////////////
  function automatic sample_t ref_fir(input sample_t h [`FAS_TAPS]);
    longint acc;
    acc = 0;
    for (int k = 0; k < `FAS_TAPS; k++) acc += longint'(h[k]) * longint'(fir_coef[k]);
    acc = (acc >>> `FAS_FRAC) + ((acc < 0) ? 1 : 0);  // negatives get one added
    return sample_t'(wrap(acc, `FAS_SAMPLE_W));
  endfunction

  // radix-2 dif model with wrap at the internal width after every op
  function automatic bins_t ref_fft(input sample_t x [`FAS_FFT_N]);
    longint re [`FAS_FFT_N];
    longint im [`FAS_FFT_N];
    longint dr, di;
    int     h, t, u, k;
    bins_t  b;
    for (int i = 0; i < `FAS_FFT_N; i++) begin
      re[i] = x[i];
      im[i] = 0;    // real input
    end
    for (int s = 0; s < $clog2(`FAS_FFT_N); s++) begin
      h = `FAS_FFT_N >> (s + 1);  // pair distance
      for (int g = 0; g < `FAS_FFT_N; g += 2 * h) begin
        for (int p = 0; p < h; p++) begin
          t = g + p;
          u = t + h;
          k = p << s;               // position in group times 2^s
          dr = wrap(re[t] - re[u], `FAS_ACC_W);
          di = wrap(im[t] - im[u], `FAS_ACC_W);
          re[t] = wrap(re[t] + re[u], `FAS_ACC_W);
          im[t] = wrap(im[t] + im[u], `FAS_ACC_W);
          re[u] = wrap((dr * tw_re[k] - di * tw_im[k]) >>> `FAS_FRAC, `FAS_ACC_W);
          im[u] = wrap((dr * tw_im[k] + di * tw_re[k]) >>> `FAS_FRAC, `FAS_ACC_W);
        end
      end
    end
    // results sit in bit-reversed positions
    for (int i = 0; i < `FAS_FFT_N; i++) begin
      b[i].re = sample_t'(re[reverse_bits(i, $clog2(`FAS_FFT_N))]);
      b[i].im = sample_t'(im[reverse_bits(i, $clog2(`FAS_FFT_N))]);
    end
    return b;
  endfunction

endpackage

//--- tb/fas_tb.sv
`include "fas_params.svh"

module fas_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import fas_stream_pkg::*;
  import fas_ref_pkg::*;

  localparam int N     = `FAS_FFT_N;
  localparam int TAPS  = `FAS_TAPS;
  localparam int FILL  = TAPS - 1;        // samples before the first output
  localparam int DRAIN = 10;              // idle cycles after each test
  localparam int T1_N  = FILL + TAPS;
  localparam int T2_N  = FILL + 200;
  localparam int T3_N  = 80;              // two partial frames around a gap
  localparam int T4_N  = FILL + 8 * N;
  localparam int T5_N  = FILL + 3 * N;
  localparam int T6_N  = FILL + 4 * N;
  localparam int WATCHDOG_NS = (T1_N + T2_N + T3_N + T4_N + T5_N + T6_N + 200) * 8;

  logic    clk, rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    fft_valid;
  bins_t   fft_bins;

  sample_t     hist [TAPS];          // accepted samples with hist[0] newest
  int          run_len = 0;
  logic        exp_fir_valid;
  sample_t     exp_fir_d;
  sample_t     cap [N];              // fir_d gathered into frames
  int          cap_idx = 0;
  logic [4:0]  exp_fft_vld;          // frame done to fft_valid delay
  bins_t       exp_bins [5];
  longint      cyc = 0;
  longint      done_cyc [$];         // edge count of each completed frame
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          fir_cnt = 0;
  int          fft_cnt = 0;
  logic [15:0] lfsr_q;
  logic        const_mode;
  sample_t     const_bin0;

  tb_clock u_clk (.clk(clk), .rst(rst));

  fas_top DUT (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .fft_valid  (fft_valid),
    .fft_bins   (fft_bins)
  );

  //////////////////////////////////////////////////////////////////////
  // reporting and stimulus helpers
  //////////////////////////////////////////////////////////////////////
  task automatic flag_value(input string sig, input longint exp, input longint act);
    err_cnt++;
    $display("[ERROR] %0d ns %s expected %0d actual %0d", $time, sig, exp, act);
  endtask

  task automatic flag_bins(input string sig, input bins_t exp, input bins_t act);
    err_cnt++;
    $display("[ERROR] %0d ns %s expected %h actual %h", $time, sig, exp, act);
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    assert (exp == act) else flag_value(what, exp, act);
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("PASS  %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL  %s with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // one lfsr step per bit taken
  function automatic sample_t draw_sample();
    sample_t v;
    v = '0;
    for (int i = 0; i < `FAS_SAMPLE_W; i++) begin
      v = {v[`FAS_SAMPLE_W-2:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic bins_t const_spectrum(input sample_t bin0);
    bins_t b;
    b = '0;
    b[0].re = bin0;  // everything else stays zero
    return b;
  endfunction

  task automatic drive_sample(input sample_t v);
    @(posedge clk);
    #1;
    data_valid = 1'b1;
    data       = v;
  endtask

  task automatic drive_random(input int n);
    repeat (n) drive_sample(draw_sample());
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      data_valid = 1'b0;
      data       = '0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model reading values from before the edge
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk or posedge rst) begin
    logic   frame_done;
    bins_t  frame_bins;
    longint delay;
    frame_done = 1'b0;
    frame_bins = '0;
    if (rst) begin
      run_len = 0;
      cap_idx = 0;
      exp_fir_valid <= 1'b0;
      exp_fft_vld   <= '0;
    end else begin
      if (data_valid) begin
        for (int k = TAPS-1; k > 0; k--) hist[k] = hist[k-1];
        hist[0] = data;
        if (run_len < TAPS) run_len++;
        exp_fir_valid <= (run_len == TAPS);  // window full
        exp_fir_d     <= ref_fir(hist);
      end else begin
        run_len = 0;                         // gap restarts the count
        exp_fir_valid <= 1'b0;
      end
      // frames counted from each rise of fir_valid
      if (fir_valid) begin
        fir_cnt++;
        cap[cap_idx] = fir_d;
        if (cap_idx == N-1) begin
          frame_done = 1'b1;
          frame_bins = ref_fft(cap);
          done_cyc.push_back(cyc);
          cap_idx = 0;
        end else cap_idx++;
      end else cap_idx = 0;                  // partial frame dropped
      // each pulse must follow its frame by 5 edges
      if (fft_valid) begin
        fft_cnt++;
        if (done_cyc.size() == 0) begin
          err_cnt++;
          $display("%0d ns fft_valid pulsed with no completed frame pending", $time);
        end else begin
          delay = cyc - done_cyc.pop_front();
          assert (delay == 5) else flag_value("fft_valid delay in edges", 5, delay);
        end
      end
      exp_fft_vld <= {exp_fft_vld[3:0], frame_done};
      exp_bins[0] <= frame_bins;
      for (int i = 1; i < 5; i++) exp_bins[i] <= exp_bins[i-1];
      cyc++;
    end
  end

  a_fir_valid: assert property (@(posedge clk) disable iff (rst) fir_valid == exp_fir_valid)
    else flag_value("fir_valid", $sampled(exp_fir_valid), $sampled(fir_valid));

  a_fir_d: assert property (@(posedge clk) disable iff (rst) fir_valid |-> fir_d == exp_fir_d)
    else flag_value("fir_d", $sampled(exp_fir_d), $sampled(fir_d));

  a_fft_valid: assert property (@(posedge clk) disable iff (rst) fft_valid == exp_fft_vld[4])
    else flag_value("fft_valid", $sampled(exp_fft_vld[4]), $sampled(fft_valid));

  a_fft_bins: assert property (@(posedge clk) disable iff (rst)
      fft_valid |-> fft_bins == exp_bins[4])
    else flag_bins("fft_bins", $sampled(exp_bins[4]), $sampled(fft_bins));

  // dc only spectrum for a constant input
  a_const_bins: assert property (@(posedge clk) disable iff (rst)
      (const_mode && fft_valid) |-> fft_bins == const_spectrum(const_bin0))
    else flag_bins("fft_bins constant", const_spectrum(const_bin0), $sampled(fft_bins));

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    sample_t cst [TAPS];
    int      fv;
    int      e0;
    int      f0;
    int      n0;
    lfsr_q     = 16'd93;
    data_valid = 1'b0;
    data       = '0;
    const_mode = 1'b0;
    const_bin0 = '0;
    @(negedge rst);

    e0 = err_cnt;  // reset values and the fill window
    assert (!fir_valid) else flag_value("fir_valid after reset", 0, fir_valid);
    assert (!fft_valid) else flag_value("fft_valid after reset", 0, fft_valid);
    f0 = fir_cnt;
    drive_random(FILL);
    idle(2);
    check_count("fir_valid count after 31 samples", 0, fir_cnt - f0);
    drive_random(TAPS);
    idle(DRAIN);
    check_count("fir_valid count after 32 samples", 1, fir_cnt - f0);
    end_test("reset and fill", e0);

    e0 = err_cnt;
    f0 = fir_cnt;
    drive_random(T2_N);
    idle(DRAIN);
    check_count("fir_valid count", T2_N - FILL, fir_cnt - f0);
    end_test("random fir values", e0);

    e0 = err_cnt;  // 9 outputs on each side of a one cycle gap
    f0 = fir_cnt;
    n0 = fft_cnt;
    drive_random(T3_N / 2);
    idle(1);
    drive_random(T3_N / 2);
    idle(DRAIN);
    check_count("fir_valid count", T3_N - 2 * FILL, fir_cnt - f0);
    check_count("fft_valid count for partial frames", 0, fft_cnt - n0);
    end_test("gap restart", e0);

    e0 = err_cnt;
    n0 = fft_cnt;
    drive_random(T4_N);
    idle(DRAIN);
    check_count("fft_valid count", 8, fft_cnt - n0);
    end_test("random spectra", e0);

    e0 = err_cnt;  // filter output steady once the window holds one value
    n0 = fft_cnt;
    for (int k = 0; k < TAPS; k++) cst[k] = 16'sd1000;
    fv = ref_fir(cst);
    const_bin0 = sample_t'(fv * N);
    const_mode = 1'b1;
    repeat (T5_N) drive_sample(16'sd1000);
    idle(DRAIN);
    const_mode = 1'b0;
    check_count("fft_valid count", 3, fft_cnt - n0);
    end_test("constant input", e0);

    e0 = err_cnt;
    n0 = fft_cnt;
    drive_random(T6_N);
    idle(DRAIN);
    check_count("fft_valid count", 4, fft_cnt - n0);
    check_count("frames still waiting for fft_valid", 0, done_cyc.size());
    end_test("frame cadence", e0);

    $display("tests passed %0d failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // stops a run that hangs
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- tb/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_NS    = 4;  // 8 ns period
  localparam int RST_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // release 1 ns after an edge like every other input
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule
